/* list.f */
+incdir+rtl
rtl/seq_pkg.sv
rtl/seq_ring_if.sv
rtl/seq_age.sv
rtl/seq_free_list.sv
rtl/seq_reclaim.sv
rtl/seq_num_alloc.sv
rtl/seq_num_top.sv
dv/tb_seq_num_top.sv

/* Bender.yml */
package:
  name: seq_num

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/seq_pkg.sv
      - rtl/seq_ring_if.sv
      - rtl/seq_age.sv
      - rtl/seq_free_list.sv
      - rtl/seq_reclaim.sv
      - rtl/seq_num_alloc.sv
      - rtl/seq_num_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_seq_num_top.sv

/* dv/tb_seq_num_top.sv */
//----------------------------------------------------------------------------
// Testbench for the sequence number generator
// Directed and seeded random stimulus, ring reference model, output compare
//----------------------------------------------------------------------------

`timescale 1ns/1ps

`include "seq_config.svh"

module tb_seq_num_top;

  localparam int RANDOM_CYCLES = 400;
  // Directed phases take a few ring lengths, random phase is fixed length
  localparam int MAX_CYCLES    = 8 * `NUM_ENTRIES + RANDOM_CYCLES + 100;

  logic                 clk;
  logic                 rst;
  logic                 alloc_val;
  logic                 alloc_rdy;
  logic                 commit_val;
  logic                 squash_val;
  seq_pkg::seq_num_t    alloc_seq_num;
  seq_pkg::seq_num_t    commit_seq_num;
  seq_pkg::seq_num_t    squash_seq_num;

  // Reference ring state
  seq_pkg::seq_num_t    m_head;
  seq_pkg::seq_num_t    m_tail;
  seq_pkg::entry_mask_t m_busy;

  string  test_name = "reset";
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  integer seed = 86742;

  seq_num_top DUT (
    .clk            (clk),
    .rst            (rst),
    .alloc_seq_num  (alloc_seq_num),
    .alloc_val      (alloc_val),
    .alloc_rdy      (alloc_rdy),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------
  // Expected grant valid and number, packed as {val, num}
  function automatic logic [`SEQ_NUM_BITS:0] expected_alloc(input logic sq,
                                                            input seq_pkg::seq_num_t sq_num);
    seq_pkg::seq_num_t nxt;
    seq_pkg::seq_num_t num;
    nxt = m_head + 1'b1;
    num = sq ? seq_pkg::seq_num_t'(sq_num + 1'b1) : m_head;
    return {nxt != m_tail, num};
  endfunction

  // One clock edge of head, tail and busy bits
  function automatic void step_model(input logic fire, input logic cm,
                                     input seq_pkg::seq_num_t cm_num, input logic sq,
                                     input seq_pkg::seq_num_t sq_num);
    seq_pkg::entry_mask_t nxt_busy;
    seq_pkg::seq_num_t    live;
    int                   k;
    // Reclaim length from the state before the edge
    live = m_head - m_tail;
    k = 0;
    while (k < `RECLAIM_WIDTH && k < live && !m_busy[seq_pkg::seq_num_t'(m_tail + k)]) begin
      k++;
    end
    nxt_busy = m_busy;
    if (fire) nxt_busy[m_head] = 1'b1;
    if (cm) nxt_busy[cm_num] = 1'b0;
    // Younger means farther from the tail than the squash point
    for (int e = 0; e < `NUM_ENTRIES; e++) begin
      if (sq && seq_pkg::seq_num_t'(e - m_tail) > seq_pkg::seq_num_t'(sq_num - m_tail)) begin
        nxt_busy[e] = 1'b0;
      end
    end
    m_busy = nxt_busy;
    if (sq) m_head = sq_num + 1'b1;
    m_head = m_head + fire;
    m_tail = m_tail + k;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  //--------------------------------------------------------------------------
  // Compare process, outputs settled mid-cycle
  //--------------------------------------------------------------------------
  always @(negedge clk) begin : compare_proc
    logic [`SEQ_NUM_BITS:0] expect_bits;
    if (rst !== 1'b0) begin
      m_head = '0;
      m_tail = '0;
      m_busy = '0;
    end else begin
      expect_bits = expected_alloc(squash_val, squash_seq_num);
      compare_value("alloc_val", expect_bits[`SEQ_NUM_BITS], alloc_val);
      if (expect_bits[`SEQ_NUM_BITS]) begin
        compare_value("alloc_seq_num", expect_bits[`SEQ_NUM_BITS-1:0], alloc_seq_num);
      end
      step_model(expect_bits[`SEQ_NUM_BITS] & alloc_rdy, commit_val, commit_seq_num,
                 squash_val, squash_seq_num);
    end
  end

  // Watchdog
  initial begin : watchdog
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Verification failed");
    $finish;
  end

  //--------------------------------------------------------------------------
  // Stimulus helpers
  //--------------------------------------------------------------------------
  task automatic commit_pulse(input seq_pkg::seq_num_t num);
    @(posedge clk);
    commit_val     <= 1'b1;
    commit_seq_num <= num;
    @(posedge clk);
    commit_val     <= 1'b0;
  endtask

  // Waits for room, then counts grants until the ring is full again
  task automatic grants_until_full(output int n);
    n = 0;
    do @(negedge clk); while (!alloc_val);
    while (alloc_val) begin
      if (alloc_rdy) n++;
      @(negedge clk);
    end
  endtask

  initial begin : stimulus
    int                n;
    int                r;
    int                live;
    seq_pkg::seq_num_t pick;
    rst            <= 1'b1;
    alloc_rdy      <= 1'b0;
    commit_val     <= 1'b0;
    commit_seq_num <= '0;
    squash_val     <= 1'b0;
    squash_seq_num <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Sequential numbers, then full after ring size minus one grants
    test_name = "sequential";
    @(posedge clk);
    alloc_rdy <= 1'b1;
    for (int i = 0; i < `NUM_ENTRIES - 1; i++) begin
      @(negedge clk);
      compare_value("alloc_seq_num", i, alloc_seq_num);
    end
    test_name = "full";
    repeat (3) begin
      @(negedge clk);
      compare_value("alloc_val", 0, alloc_val);
    end

    // Oldest commits, room returns two edges later
    test_name = "in_order";
    for (int i = 0; i < 2; i++) begin
      commit_pulse(i);
      @(negedge clk);
      compare_value("alloc_val", 0, alloc_val);
      @(negedge clk);
      compare_value("alloc_val", 1, alloc_val);
      compare_value("alloc_seq_num", (`NUM_ENTRIES - 1 + i) % `NUM_ENTRIES, alloc_seq_num);
    end

    // Younger first, then the oldest releases all seven
    test_name = "out_of_order";
    for (int i = 1; i < 7; i++) begin
      commit_pulse(m_tail + i);
      @(negedge clk);
      compare_value("alloc_val", 0, alloc_val);
    end
    commit_pulse(m_tail);
    grants_until_full(n);
    compare_value("grants", 7, n);

    // Squash four past the tail, five entries stay live
    test_name = "squash";
    pick = m_tail + 3'd4;
    @(posedge clk);
    squash_val     <= 1'b1;
    squash_seq_num <= pick;
    @(negedge clk);
    compare_value("alloc_seq_num", seq_pkg::seq_num_t'(pick + 1'b1), alloc_seq_num);
    @(posedge clk);
    squash_val <= 1'b0;
    grants_until_full(n);
    compare_value("grants", `NUM_ENTRIES - 1 - 5, n);

    test_name = "random";
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      @(posedge clk);
      live = int'(seq_pkg::seq_num_t'(m_head - m_tail));
      r    = $unsigned($random(seed)) % 16;
      pick = m_tail + seq_pkg::seq_num_t'($unsigned($random(seed)) % (live == 0 ? 1 : live));
      alloc_rdy  <= ($random(seed) % 2) != 0;
      commit_val <= 1'b0;
      squash_val <= 1'b0;
      if (live != 0 && r < 7 && m_busy[pick]) begin
        commit_val     <= 1'b1;
        commit_seq_num <= pick;
      end else if (live != 0 && r == 15) begin
        // No grant alongside a squash
        squash_val     <= 1'b1;
        squash_seq_num <= pick;
        alloc_rdy      <= 1'b0;
      end
    end
    @(posedge clk);
    commit_val <= 1'b0;
    squash_val <= 1'b0;
    repeat (2) @(negedge clk);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* rtl/seq_num_top.sv */
//----------------------------------------------------------------------------
// Sequence number generator top level
// Allocator, free list, tail reclaim and age mask joined by the ring bundle
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module seq_num_top (
  input  logic              clk,
  input  logic              rst,

  //--------------------------------------------------------------------------
  // Allocation, valid/ready
  //--------------------------------------------------------------------------
  output seq_pkg::seq_num_t alloc_seq_num,
  output logic              alloc_val,
  input  logic              alloc_rdy,

  //--------------------------------------------------------------------------
  // Commit, one pulse per number
  //--------------------------------------------------------------------------
  input  logic              commit_val,
  input  seq_pkg::seq_num_t commit_seq_num,

  //--------------------------------------------------------------------------
  // Squash, single-cycle pulse
  //--------------------------------------------------------------------------
  input  logic              squash_val,
  input  seq_pkg::seq_num_t squash_seq_num
);

  // Shared head, tail, grant and busy state
  seq_ring_if ring ();

  // Entries younger than the squash point
  seq_pkg::entry_mask_t squash_younger;

  // Head pointer and grant
  seq_num_alloc u_alloc (
    .clk            (clk),
    .rst            (rst),
    .ring           (ring.alloc),
    .alloc_seq_num  (alloc_seq_num),
    .alloc_val      (alloc_val),
    .alloc_rdy      (alloc_rdy),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num)
  );

  // Age order only needs the tail
  seq_age u_age (
    .tail_ptr       (ring.tail_ptr),
    .squash_seq_num (squash_seq_num),
    .younger        (squash_younger)
  );

  // Busy bits
  seq_free_list u_free_list (
    .clk            (clk),
    .rst            (rst),
    .ring           (ring.free_list),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .squash_val     (squash_val),
    .younger        (squash_younger)
  );

  // Tail pointer
  seq_reclaim u_reclaim (
    .clk  (clk),
    .rst  (rst),
    .ring (ring.reclaim)
  );

endmodule

/* rtl/seq_num_alloc.sv */
//----------------------------------------------------------------------------
// Allocator
// Head pointer, full check, valid/ready grant and squash redirect
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module seq_num_alloc (
  input  logic              clk,
  input  logic              rst,
  seq_ring_if.alloc         ring,
  output seq_pkg::seq_num_t alloc_seq_num,
  output logic              alloc_val,
  input  logic              alloc_rdy,
  input  logic              squash_val,
  input  seq_pkg::seq_num_t squash_seq_num
);

  seq_pkg::seq_num_t head_q;
  seq_pkg::seq_num_t head_next;
  seq_pkg::seq_num_t head_inc;
  seq_pkg::seq_num_t redirect;

  //--------------------------------------------------------------------------
  // Full check and grant
  //--------------------------------------------------------------------------
  // One slot kept empty between head and tail
  assign head_inc   = ring.head_ptr + 1'b1;
  assign alloc_val  = head_inc != ring.tail_ptr;

  // Same-cycle grant
  assign ring.alloc_fire = alloc_val & alloc_rdy;

  // Squash restarts numbering just after the squashing instruction
  assign redirect      = squash_seq_num + 1'b1;
  assign alloc_seq_num = squash_val ? redirect : ring.head_ptr;

  //--------------------------------------------------------------------------
  // Head register
  //--------------------------------------------------------------------------
  always_comb begin
    head_next = head_q;
    if (squash_val) begin
      head_next = redirect;
    end
    // Grant on top of the redirect
    if (ring.alloc_fire) begin
      head_next = head_next + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
    end else begin
      head_q <= head_next;
    end
  end

  assign ring.head_ptr = head_q;

endmodule

/* rtl/seq_reclaim.sv */
//----------------------------------------------------------------------------
// Tail reclaim
// Tail pointer register advancing over freed entries at the oldest end
//----------------------------------------------------------------------------

`timescale 1ns/1ps

`include "seq_config.svh"

module seq_reclaim (
  input  logic       clk,
  input  logic       rst,
  seq_ring_if.reclaim ring
);

  seq_pkg::seq_num_t         tail_q;
  seq_pkg::seq_num_t         live_cnt;
  seq_pkg::seq_num_t         tail_incr;
  logic [`RECLAIM_WIDTH-1:0] reclaim_valid;

  //--------------------------------------------------------------------------
  // Live window
  //--------------------------------------------------------------------------
  // Entries tail .. head-1 are live; never step past the head
  assign live_cnt = ring.head_ptr - ring.tail_ptr;

  //--------------------------------------------------------------------------
  // Chained valid vector
  //--------------------------------------------------------------------------
  // Bit i set only when entries tail .. tail+i are all live and free
  always_comb begin : valid_chain
    logic              run;
    seq_pkg::seq_num_t idx;

    run = 1'b1;
    for (int i = 0; i < `RECLAIM_WIDTH; i++) begin
      // Index wraps around the ring
      idx = ring.tail_ptr + seq_pkg::seq_num_t'(i);
      run = run & ~ring.busy[idx] & (seq_pkg::seq_num_t'(i) < live_cnt);
      reclaim_valid[i] = run;
    end
  end

  //--------------------------------------------------------------------------
  // Longest prefix
  //--------------------------------------------------------------------------
  // Vector is a thermometer code, so the last set bit gives the length
  always_comb begin
    tail_incr = '0;
    for (int i = 0; i < `RECLAIM_WIDTH; i++) begin
      if (reclaim_valid[i]) begin
        tail_incr = seq_pkg::seq_num_t'(i + 1);
      end
    end
  end

  //--------------------------------------------------------------------------
  // Tail register
  //--------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      tail_q <= '0;
    end else begin
      tail_q <= tail_q + tail_incr;
    end
  end

  assign ring.tail_ptr = tail_q;

endmodule

/* rtl/seq_free_list.sv */
//----------------------------------------------------------------------------
// Free list
// Per-entry busy bits, set on allocation, cleared on commit and squash
//----------------------------------------------------------------------------

`timescale 1ns/1ps

module seq_free_list (
  input  logic                 clk,
  input  logic                 rst,
  seq_ring_if.free_list        ring,
  input  logic                 commit_val,
  input  seq_pkg::seq_num_t    commit_seq_num,
  input  logic                 squash_val,
  input  seq_pkg::entry_mask_t younger
);

  seq_pkg::entry_mask_t busy_q;
  seq_pkg::entry_mask_t busy_next;

  //--------------------------------------------------------------------------
  // Next-state
  //--------------------------------------------------------------------------
  // Later updates override earlier ones, so clearing wins over allocation
  always_comb begin
    busy_next = busy_q;

    // Allocation marks the head entry
    if (ring.alloc_fire) begin
      busy_next[ring.head_ptr] = 1'b1;
    end

    // Commit frees one entry, any order
    if (commit_val) begin
      busy_next[commit_seq_num] = 1'b0;
    end

    // Squash frees everything younger than the squash point
    if (squash_val) begin
      busy_next = busy_next & ~younger;
    end
  end

  //--------------------------------------------------------------------------
  // Busy register
  //--------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_next;
    end
  end

  assign ring.busy = busy_q;

endmodule

/* rtl/seq_age.sv */
//----------------------------------------------------------------------------
// Age comparator
// Mask of ring entries younger than a squash point, measured from the tail
//----------------------------------------------------------------------------

`timescale 1ns/1ps

`include "seq_config.svh"

module seq_age (
  input  seq_pkg::seq_num_t    tail_ptr,
  input  seq_pkg::seq_num_t    squash_seq_num,
  output seq_pkg::entry_mask_t younger
);

  //--------------------------------------------------------------------------
  // Squash point distance
  //--------------------------------------------------------------------------
  // Tail is the oldest live entry, so distance from it gives age order
  seq_pkg::seq_num_t squash_dist;

  assign squash_dist = squash_seq_num - tail_ptr;

  //--------------------------------------------------------------------------
  // Per-entry compare
  //--------------------------------------------------------------------------
  // Same compare replicated for every index in parallel
  for (genvar e = 0; e < `NUM_ENTRIES; e++) begin : g_entry
    seq_pkg::seq_num_t entry_dist;

    // Wraps modulo ring size
    assign entry_dist = seq_pkg::seq_num_t'(e) - tail_ptr;

    // Strictly younger only, the squash point itself stays live
    assign younger[e] = entry_dist > squash_dist;
  end

endmodule

/* rtl/seq_ring_if.sv */
//----------------------------------------------------------------------------
// Ring state bundle shared by the allocator, free list and reclaim logic
// Head and tail pointers, allocation fire, busy vector
//----------------------------------------------------------------------------

`timescale 1ns/1ps

interface seq_ring_if;

  // Next number to hand out
  seq_pkg::seq_num_t   head_ptr;
  // Oldest live number
  seq_pkg::seq_num_t   tail_ptr;
  // Allocation granted this cycle
  logic                alloc_fire;
  // Entry holds an in-flight instruction
  seq_pkg::entry_mask_t busy;

  // Allocator owns the head
  modport alloc (
    output head_ptr,
    output alloc_fire,
    input  tail_ptr
  );

  // Busy bits, set at the head on allocation
  modport free_list (
    output busy,
    input  head_ptr,
    input  alloc_fire
  );

  // Tail walks over freed entries
  modport reclaim (
    output tail_ptr,
    input  head_ptr,
    input  busy
  );

endinterface

/* rtl/seq_pkg.sv */
//----------------------------------------------------------------------------
// Shared types for the sequence number generator
// Sequence number / ring index and per-entry mask
//----------------------------------------------------------------------------

`include "seq_config.svh"

package seq_pkg;

  //--------------------------------------------------------------------------
  // Sequence number
  //--------------------------------------------------------------------------
  // Doubles as ring index, all arithmetic wraps at the ring size
  typedef logic [`SEQ_NUM_BITS-1:0] seq_num_t;

  //--------------------------------------------------------------------------
  // Entry mask
  //--------------------------------------------------------------------------
  // One bit per ring entry
  // Used for the busy vector and for the squash mask
  typedef logic [`NUM_ENTRIES-1:0] entry_mask_t;

endpackage

/* rtl/seq_config.svh */
//----------------------------------------------------------------------------
// Sizing macros for the sequence number generator
// Number width, ring size and tail reclaim width
//----------------------------------------------------------------------------

`ifndef SEQ_CONFIG_SVH
`define SEQ_CONFIG_SVH

// Width of one sequence number, also the ring index width
`define SEQ_NUM_BITS 5

// Max entries the tail can step over per cycle, 1 up to ring size
`define RECLAIM_WIDTH 2

// Ring size
`define NUM_ENTRIES (1 << `SEQ_NUM_BITS)

`endif
